// ==== Makefile ====
# Verilator build and run of the ser_link testbench

VERILATOR ?= verilator
TOP       ?= ser_link_tb
FILELIST  ?= ser_link.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

# output is shown, status comes from the search for the pass message
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | \
		awk -v msg="$(PASS_MSG)" '{ print } index($$0, msg) { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// ==== include/ser_link_cfg.svh ====
`ifndef SER_LINK_CFG_SVH
`define SER_LINK_CFG_SVH

// parallel word width
`define SER_PW 64

// lane width in bits per beat
`define SER_SW 2

// beat counter width, one bit more than log2 of beats per word
`define SER_CW ($clog2(`SER_PW / `SER_SW) + 1)

`endif

// ==== ser_link.f ====
+incdir+include
verilog/ser_link_pkg.sv
verilog/ser_ctrl_if.sv
verilog/ser_lane_if.sv
verilog/ser_cmd_decode.sv
verilog/ser_par2ser.sv
verilog/ser_ser2par.sv
verilog/ser_rx_result.sv
verilog/ser_link.sv
test/tb_clock_gen.sv
test/ser_link_assert.sv
test/ser_link_tb.sv

// ==== test/ser_link_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module ser_link_assert (
   input logic clk,
   input logic nreset,
   input logic load,       // decoder to serializer start
   input logic busy,       // serializer still shifting
   input logic rx_valid,
   input logic lane_valid,
   input logic lane_last
);

   int fail_count = 0; // failed assertions so far

   //####################################################################
   // control path
   //####################################################################
   // serializer goes busy right after a load so no second load gets in
   property load_starts_busy;
      @(posedge clk) disable iff (!nreset) load |=> busy;
   endproperty

   load_busy_a: assert property (load_starts_busy)
      else begin
         fail_count++;
         $error("serializer not busy after load");
      end

   // result strobe is a single cycle
   property rx_single_pulse;
      @(posedge clk) disable iff (!nreset) rx_valid |=> !rx_valid;
   endproperty

   rx_pulse_a: assert property (rx_single_pulse)
      else begin
         fail_count++;
         $error("rx_valid high for more than one cycle");
      end

   // lane stays valid up to and including the last beat
   property lane_holds_to_last;
      @(posedge clk) disable iff (!nreset) (lane_valid && !lane_last) |=> lane_valid;
   endproperty

   lane_last_a: assert property (lane_holds_to_last)
      else begin
         fail_count++;
         $error("lane_valid dropped before the last beat");
      end

endmodule

`default_nettype wire

// ==== test/ser_link_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ser_link_cfg.svh"

module ser_link_tb;

   localparam int PW        = `SER_PW;
   localparam int SW        = `SER_SW;
   localparam int MAX_BEATS = PW / SW;
   localparam int PERIOD    = 100;
   localparam int MAX_HOLD  = 20; // longest link_wait hold
   localparam int N_XFERS   = 16; // transfers over all tests plus one spare for idle checks
   localparam int N_ERRS    = 3;
   // N+10 cycles per command at the longest size
   localparam int WATCHDOG_CYCLES = 4 + N_XFERS * (MAX_BEATS + 10) + N_ERRS * 10 + MAX_HOLD;

   typedef struct packed {
      logic [PW-1:0] word;
      logic [7:0]    n;
      logic          lsb;
      logic          timed; // latency checked
      logic [63:0]   t0;    // drive time of the command
   } xfer_t;

   logic              clk;
   logic              nreset;
   logic              cmd_valid;
   ser_link_pkg::op_e cmd_op;
   logic [PW-1:0]     cmd_word;
   logic [7:0]        cmd_size;
   logic              link_wait;
   logic              cmd_busy;
   logic              cmd_error;
   logic [SW-1:0]     lane_data;
   logic              lane_valid;
   logic              rx_valid;
   logic [PW-1:0]     rx_word;

   integer        seed;
   int            errors       = 0;
   int            tests_run    = 0;
   int            tests_failed = 0;
   int            err_expected = 0; // cmd_error pulses still due
   xfer_t         xfer_q[$];        // good commands not yet received
   logic [SW-1:0] lane_beats[$];    // beats of the word in flight

   tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(4)) clock_i (.clk(clk), .nreset(nreset));

   ser_link dut_i (
      .clk(clk), .nreset(nreset), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
      .cmd_word(cmd_word), .cmd_size(cmd_size), .link_wait(link_wait),
      .cmd_busy(cmd_busy), .cmd_error(cmd_error), .lane_data(lane_data),
      .lane_valid(lane_valid), .rx_valid(rx_valid), .rx_word(rx_word)
   );

   bind ser_link ser_link_assert assert_i (
      .clk(clk), .nreset(nreset), .load(ctrl_i.load), .busy(ctrl_i.busy),
      .rx_valid(rx_valid), .lane_valid(lane_valid), .lane_last(lane_i.last)
   );

   //####################################################################
   // reference model of lane beats and received word
   //####################################################################
   function automatic logic [SW-1:0] ref_beat(input logic [PW-1:0] w, input int k,
                                              input logic lsb);
      if (lsb) return w[k*SW +: SW];
      return w[PW-(k+1)*SW +: SW];
   endfunction

   // low n beats for lsb first or top n beats moved down for msb first
   function automatic logic [PW-1:0] ref_word(input logic [PW-1:0] w, input int n,
                                              input logic lsb);
      logic [PW-1:0] r;
      r = '0;
      for (int i = 0; i < n*SW; i++) begin
         r[i] = lsb ? w[i] : w[PW - n*SW + i];
      end
      return r;
   endfunction

   task automatic check_rx();
      xfer_t         x;
      logic [SW-1:0] exp_beat;
      logic [PW-1:0] exp_word;
      int            cycles;
      if (xfer_q.size() == 0) begin
         errors++;
         $display("rx_valid pulsed with no transfer outstanding at %0t", $time);
         lane_beats.delete();
         return;
      end
      x = xfer_q.pop_front();
      if (lane_beats.size() != int'(x.n)) begin
         errors++;
         $display("FAIL lane_valid beat count: got %0h expected %0h", lane_beats.size(), x.n);
      end
      for (int k = 0; k < lane_beats.size() && k < int'(x.n); k++) begin
         exp_beat = ref_beat(x.word, k, x.lsb);
         if (lane_beats[k] !== exp_beat) begin
            errors++;
            $display("FAIL lane_data beat %0d: got %0h expected %0h", k, lane_beats[k], exp_beat);
         end
      end
      exp_word = ref_word(x.word, int'(x.n), x.lsb);
      if (rx_word !== exp_word) begin
         errors++;
         $display("FAIL rx_word: got %0h expected %0h", rx_word, exp_word);
      end
      cycles = int'(($time - x.t0) / PERIOD); // drive edge to observing edge
      if (x.timed && cycles != int'(x.n) + 3) begin
         errors++;
         $display("FAIL rx_valid latency: got %0h expected %0h", cycles, int'(x.n) + 3);
      end
      lane_beats.delete();
   endtask

   // monitor samples mid cycle
   always @(negedge clk) begin
      if (nreset) begin
         if (lane_valid) lane_beats.push_back(lane_data);
         if (cmd_error) begin
            if (err_expected > 0) begin
               err_expected--;
            end else begin
               errors++;
               $display("unexpected cmd_error pulse at %0t", $time);
            end
         end
         if (rx_valid) check_rx();
      end
   end

   //####################################################################
   // stimulus helpers entered and left on a falling edge
   //####################################################################
   task automatic send_cmd(input ser_link_pkg::op_e op, input logic [PW-1:0] word,
                           input logic [7:0] size, input logic timed);
      xfer_t x;
      logic  good;
      while (cmd_busy) @(negedge clk);
      good = (op == ser_link_pkg::OP_SEND_MSB || op == ser_link_pkg::OP_SEND_LSB) &&
             size >= 8'd1 && size <= 8'(MAX_BEATS);
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_word  = word;
      cmd_size  = size;
      if (good) begin
         x.word  = word;
         x.n     = size;
         x.lsb   = (op == ser_link_pkg::OP_SEND_LSB);
         x.timed = timed;
         x.t0    = $time;
         xfer_q.push_back(x);
      end else begin
         err_expected++; // one error pulse due for a rejected command
      end
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      @(posedge clk);
      while ((xfer_q.size() != 0 || err_expected != 0) && n < MAX_BEATS + 10) begin
         @(posedge clk);
         n++;
      end
      if (xfer_q.size() != 0 || err_expected != 0) begin
         errors++;
         $display("a word or cmd_error pulse never arrived within %0d cycles", n);
         xfer_q.delete();
         err_expected = 0;
      end
      @(negedge clk);
   endtask

   task automatic end_test(input string name, input int e0);
      tests_run++;
      if (errors == e0) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - e0);
      end
   endtask

   task automatic send_rejected(input ser_link_pkg::op_e op, input logic [7:0] size);
      send_cmd(op, {$random(seed), $random(seed)}, size, 1'b0);
      if (cmd_error !== 1'b1) begin
         errors++;
         $display("cmd_error did not pulse one cycle after the rejected command");
      end
      repeat (4) begin
         if (lane_valid || rx_valid) begin
            errors++;
            $display("rejected command op %0d size %0d still reached the lane", op, size);
         end
         @(negedge clk);
      end
      wait_drained();
   endtask

   //####################################################################
   // directed tests
   //####################################################################
   task automatic reset_test();
      int e0;
      e0 = errors;
      if ({cmd_busy, cmd_error, lane_valid, rx_valid} !== 4'h0) begin
         errors++;
         $display("FAIL cmd_busy,cmd_error,lane_valid,rx_valid after reset: got %0h expected 0",
                  {cmd_busy, cmd_error, lane_valid, rx_valid});
      end
      end_test("reset values", e0);
   endtask

   task automatic msb_full_test();
      int e0;
      e0 = errors;
      send_cmd(ser_link_pkg::OP_SEND_MSB, {$random(seed), $random(seed)}, 8'(MAX_BEATS), 1'b1);
      wait_drained();
      end_test("msb full word", e0);
   endtask

   task automatic lsb_partial_test();
      int         e0;
      logic [7:0] n;
      e0 = errors;
      repeat (4) begin
         n = 8'(($unsigned($random(seed)) % (MAX_BEATS - 1)) + 1); // 1 to 31 beats
         send_cmd(ser_link_pkg::OP_SEND_LSB, {$random(seed), $random(seed)}, n, 1'b1);
         wait_drained();
      end
      end_test("lsb partial", e0);
   endtask

   task automatic bad_cmd_test();
      int e0;
      e0 = errors;
      send_rejected(ser_link_pkg::OP_RSVD2, 8'd4);
      send_rejected(ser_link_pkg::OP_SEND_MSB, 8'd0);
      send_rejected(ser_link_pkg::OP_SEND_LSB, 8'(MAX_BEATS + 1));
      end_test("bad commands", e0);
   endtask

   task automatic link_wait_test();
      int e0;
      int hold;
      e0   = errors;
      hold = int'($unsigned($random(seed)) % MAX_HOLD) + 1;
      send_cmd(ser_link_pkg::OP_SEND_LSB, {$random(seed), $random(seed)}, 8'd16, 1'b0);
      link_wait = 1'b1; // command now parked in the decoder
      repeat (hold) begin
         @(negedge clk);
         if (lane_valid) begin
            errors++;
            $display("lane_valid rose while link_wait was high");
         end
      end
      link_wait = 1'b0;
      wait_drained();
      end_test("link_wait hold", e0);
   endtask

   task automatic busy_ignore_test();
      int e0;
      e0 = errors;
      send_cmd(ser_link_pkg::OP_SEND_MSB, {$random(seed), $random(seed)}, 8'd8, 1'b1);
      cmd_valid = 1'b1; // second command dropped while busy
      cmd_op    = ser_link_pkg::OP_SEND_LSB;
      cmd_word  = {$random(seed), $random(seed)};
      cmd_size  = 8'd4;
      repeat (3) begin
         if (!cmd_busy) begin
            errors++;
            $display("cmd_busy low while a command was in flight");
         end
         @(negedge clk);
      end
      cmd_valid = 1'b0;
      wait_drained();
      repeat (10) begin
         @(negedge clk);
         if (lane_valid) begin
            errors++;
            $display("the command sent during cmd_busy reached the lane");
         end
      end
      end_test("busy ignore", e0);
   endtask

   task automatic mixed_test();
      int                e0;
      ser_link_pkg::op_e op;
      logic [7:0]        n;
      e0 = errors;
      repeat (8) begin
         op = ser_link_pkg::op_e'(2'($random(seed)));
         n  = 8'($unsigned($random(seed)) % (MAX_BEATS + 3)); // sizes 0 to 34
         send_cmd(op, {$random(seed), $random(seed)}, n, 1'b1);
      end
      wait_drained();
      end_test("mixed back to back", e0);
   endtask

   //####################################################################
   // main sequence and watchdog
   //####################################################################
   initial begin
      seed      = 32'h8f0b4dce;
      cmd_valid = 1'b0;
      cmd_op    = ser_link_pkg::OP_SEND_MSB;
      cmd_word  = '0;
      cmd_size  = '0;
      link_wait = 1'b0;
      wait (nreset === 1'b1);
      @(negedge clk);
      reset_test();
      msb_full_test();
      lsb_partial_test();
      bad_cmd_test();
      link_wait_test();
      busy_ignore_test();
      mixed_test();
      $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
               tests_run, tests_failed, errors, dut_i.assert_i.fail_count);
      if (errors == 0 && tests_failed == 0 && dut_i.assert_i.fail_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout, tests still running after %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD       = 100, // ns
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic nreset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // reset held for a few rising edges
   initial begin
      nreset = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1; // released away from the active edge
   end

endmodule

`default_nettype wire

// ==== verilog/ser_cmd_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ser_link_cfg.svh"

module ser_cmd_decode (
   input  logic                clk,
   input  logic                nreset,
   input  logic                cmd_valid,  // command strobe
   input  ser_link_pkg::op_e   cmd_op,
   input  logic [`SER_PW-1:0]  cmd_word,
   input  logic [7:0]          cmd_size,   // beats requested
   input  logic                link_wait,  // holds off new transfers
   output logic                cmd_busy,
   output logic                cmd_error,  // pulse per rejected command
   ser_ctrl_if.decoder         ctrl
);

   localparam int CW        = `SER_CW;
   localparam int MAX_BEATS = `SER_PW / `SER_SW;

   logic accept;  // command taken this edge
   logic op_ok;
   logic size_ok;
   logic cmd_ok;
   logic pending; // good command waiting for serializer

   //####################################################################
   // command checks
   //####################################################################
   assign accept  = cmd_valid & ~cmd_busy;
   assign op_ok   = (cmd_op == ser_link_pkg::OP_SEND_MSB) ||
                    (cmd_op == ser_link_pkg::OP_SEND_LSB);
   assign size_ok = (cmd_size != 8'd0) && (cmd_size <= 8'(MAX_BEATS));
   assign cmd_ok  = op_ok & size_ok;

   // busy while holding a command, shifting or held off
   assign cmd_busy = pending | ctrl.busy | link_wait;

   // start only into an idle serializer with no wait
   assign ctrl.load = pending & ~ctrl.busy & ~link_wait;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         pending   <= 1'b0;
         cmd_error <= 1'b0;
      end else begin
         cmd_error <= accept & ~cmd_ok; // one cycle after acceptance
         if (accept & cmd_ok) begin
            pending <= 1'b1;
         end else if (ctrl.load) begin
            pending <= 1'b0;            // handed to serializer
         end
      end
   end

   // command fields, stable until next good command
   always_ff @(posedge clk) begin
      if (accept & cmd_ok) begin
         ctrl.word     <= cmd_word;
         ctrl.beats    <= cmd_size[CW-1:0];
         ctrl.lsbfirst <= (cmd_op == ser_link_pkg::OP_SEND_LSB);
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ser_ctrl_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ser_link_cfg.svh"

// command path from decoder into serializer and deserializer
interface ser_ctrl_if;

   logic                 load;     // single cycle, only while busy low
   logic [`SER_PW-1:0]   word;     // word to send
   logic [`SER_CW-1:0]   beats;    // beat count of the transfer
   logic                 lsbfirst; // order of beats on the lane
   logic                 busy;     // serializer still shifting

   // fields held steady from one load to the next
   modport decoder (
      output load,
      output word,
      output beats,
      output lsbfirst,
      input  busy
   );

   modport serializer (
      input  load,
      input  word,
      input  beats,
      input  lsbfirst,
      output busy
   );

   // deserializer side only needs size and order
   modport receiver (
      input  beats,
      input  lsbfirst
   );

endinterface

`default_nettype wire

// ==== verilog/ser_lane_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ser_link_cfg.svh"

//####################################################################
// one serial lane, serializer to deserializer
//####################################################################
interface ser_lane_if;

   logic [`SER_SW-1:0] data;     // one beat
   logic               valid;    // beat present this cycle
   logic               last;     // final beat of the word
   logic               lsbfirst; // order of the current word

   modport sender (
      output data,
      output valid,
      output last,
      output lsbfirst
   );

   modport receiver (
      input  data,
      input  valid,
      input  last,
      input  lsbfirst
   );

endinterface

`default_nettype wire

// ==== verilog/ser_link.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ser_link_cfg.svh"

module ser_link (
   input  logic                clk,
   input  logic                nreset,
   input  logic                cmd_valid,
   input  ser_link_pkg::op_e   cmd_op,
   input  logic [`SER_PW-1:0]  cmd_word,
   input  logic [7:0]          cmd_size,
   input  logic                link_wait,
   output logic                cmd_busy,
   output logic                cmd_error,
   output logic [`SER_SW-1:0]  lane_data,
   output logic                lane_valid,
   output logic                rx_valid,
   output logic [`SER_PW-1:0]  rx_word
);

   logic [`SER_PW-1:0] raw_word;
   logic               raw_done;
   logic [`SER_CW-1:0] raw_beats;
   logic               raw_lsbfirst;

   ser_ctrl_if ctrl_i ();
   ser_lane_if lane_i ();

   //####################################################################
   // transmit side
   //####################################################################
   ser_cmd_decode decode_i (
      .clk       (clk),
      .nreset    (nreset),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_word  (cmd_word),
      .cmd_size  (cmd_size),
      .link_wait (link_wait),
      .cmd_busy  (cmd_busy),
      .cmd_error (cmd_error),
      .ctrl      (ctrl_i.decoder)
   );

   ser_par2ser p2s_i (
      .clk    (clk),
      .nreset (nreset),
      .ctrl   (ctrl_i.serializer),
      .lane   (lane_i.sender)
   );

   // lane brought out for observation
   assign lane_data  = lane_i.data;
   assign lane_valid = lane_i.valid;

   // receive side
   ser_ser2par s2p_i (
      .clk          (clk),
      .nreset       (nreset),
      .lane         (lane_i.receiver),
      .ctrl         (ctrl_i.receiver),
      .raw_word     (raw_word),
      .raw_done     (raw_done),
      .raw_beats    (raw_beats),
      .raw_lsbfirst (raw_lsbfirst)
   );

   ser_rx_result result_i (
      .clk      (clk),
      .nreset   (nreset),
      .raw_word (raw_word),
      .raw_done (raw_done),
      .beats    (raw_beats),
      .lsbfirst (raw_lsbfirst),
      .rx_valid (rx_valid),
      .rx_word  (rx_word)
   );

endmodule

`default_nettype wire

// ==== verilog/ser_link_pkg.sv ====
`default_nettype none

package ser_link_pkg;

   //####################################################################
   // command opcodes
   //####################################################################
   typedef enum logic [1:0] {
      OP_SEND_MSB = 2'd0, // word goes out top beat first
      OP_SEND_LSB = 2'd1, // word goes out bottom beat first
      OP_RSVD2    = 2'd2, // reserved, rejected by decoder
      OP_RSVD3    = 2'd3  // reserved, rejected by decoder
   } op_e;

   // deserializer states
   typedef enum logic {
      RX_IDLE    = 1'b0, // waiting for first beat of a word
      RX_COLLECT = 1'b1  // beats of a word arriving
   } rx_state_e;

endpackage

`default_nettype wire

// ==== verilog/ser_par2ser.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ser_link_cfg.svh"

module ser_par2ser (
   input  logic           clk,
   input  logic           nreset,
   ser_ctrl_if.serializer ctrl,
   ser_lane_if.sender     lane
);

   localparam int   PW   = `SER_PW;
   localparam int   SW   = `SER_SW;
   localparam int   CW   = `SER_CW;
   localparam logic FILL = 1'b0; // bit shifted in behind the data

   logic [PW-1:0] shreg;
   logic [CW-1:0] count;  // beats still to send
   logic          order;  // lsb first for current word
   logic          active;

   //####################################################################
   // beat counter
   //####################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         count <= '0;
         order <= 1'b0;
      end else if (ctrl.load) begin
         count <= ctrl.beats;      // new transfer
         order <= ctrl.lsbfirst;
      end else if (active) begin
         count <= count - 1'b1;    // one beat per cycle
      end
   end

   assign active    = |count;
   assign ctrl.busy = active;

   // shift register, zeros fill in behind
   always_ff @(posedge clk) begin
      if (ctrl.load) begin
         shreg <= ctrl.word;
      end else if (active & order) begin
         shreg <= {{SW{FILL}}, shreg[PW-1:SW]};
      end else if (active) begin
         shreg <= {shreg[PW-SW-1:0], {SW{FILL}}};
      end
   end

   // lane outputs
   assign lane.valid    = active;
   assign lane.last     = (count == CW'(1)); // final beat
   assign lane.lsbfirst = order;
   assign lane.data     = order ? shreg[SW-1:0] : shreg[PW-1 -: SW];

endmodule

`default_nettype wire

// ==== verilog/ser_rx_result.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ser_link_cfg.svh"

module ser_rx_result (
   input  logic                clk,
   input  logic                nreset,
   input  logic [`SER_PW-1:0]  raw_word,
   input  logic                raw_done,
   input  logic [`SER_CW-1:0]  beats,
   input  logic                lsbfirst,
   output logic                rx_valid,  // one cycle per word
   output logic [`SER_PW-1:0]  rx_word
);

   localparam int PW = `SER_PW;
   localparam int SW = `SER_SW;
   localparam int NW = $clog2(PW) + 1; // holds bit counts up to PW

   logic [NW-1:0] nbits;   // valid data bits
   logic [NW-1:0] shamt;   // empty bits below lsb first data
   logic [PW-1:0] aligned;
   logic [PW-1:0] mask;

   //####################################################################
   // align and zero extend
   //####################################################################
   assign nbits   = NW'(beats) * NW'(SW);
   assign shamt   = NW'(PW) - nbits;
   assign aligned = lsbfirst ? (raw_word >> shamt) : raw_word; // msb first already low
   assign mask    = ~({PW{1'b1}} << nbits); // all ones for a full word

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= raw_done;
      end
   end

   always_ff @(posedge clk) begin
      if (raw_done) begin
         rx_word <= aligned & mask;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ser_ser2par.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ser_link_cfg.svh"

module ser_ser2par (
   input  logic                clk,
   input  logic                nreset,
   ser_lane_if.receiver        lane,
   ser_ctrl_if.receiver        ctrl,
   output logic [`SER_PW-1:0]  raw_word,     // beats as collected
   output logic                raw_done,     // word complete
   output logic [`SER_CW-1:0]  raw_beats,    // beats in raw_word
   output logic                raw_lsbfirst  // collection order
);

   localparam int PW = `SER_PW;
   localparam int SW = `SER_SW;

   ser_link_pkg::rx_state_e state;
   ser_link_pkg::rx_state_e state_nxt;

   logic          end_beat; // last beat present on lane
   logic [PW-1:0] base;     // word the next beat shifts into

   assign end_beat = lane.valid & lane.last;

   //####################################################################
   // state machine
   //####################################################################
   always_comb begin
      state_nxt = state;
      case (state)
         ser_link_pkg::RX_IDLE: begin
            if (lane.valid & ~lane.last) begin
               state_nxt = ser_link_pkg::RX_COLLECT; // more beats follow
            end
         end
         ser_link_pkg::RX_COLLECT: begin
            if (end_beat) begin
               state_nxt = ser_link_pkg::RX_IDLE;
            end
         end
         default: state_nxt = ser_link_pkg::RX_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state    <= ser_link_pkg::RX_IDLE;
         raw_done <= 1'b0;
      end else begin
         state    <= state_nxt;
         raw_done <= end_beat; // word holds last beat from here
      end
   end

   // first beat starts from a clean word
   assign base = (state == ser_link_pkg::RX_IDLE) ? '0 : raw_word;

   always_ff @(posedge clk) begin
      if (lane.valid) begin
         if (lane.lsbfirst) begin
            raw_word <= {lane.data, base[PW-1:SW]};    // enters at top
         end else begin
            raw_word <= {base[PW-SW-1:0], lane.data};  // enters at bottom
         end
      end
      // size and order go along with the done pulse
      if (end_beat) begin
         raw_beats    <= ctrl.beats;
         raw_lsbfirst <= ctrl.lsbfirst;
      end
   end

endmodule

`default_nettype wire
